// ==== source/bridge_cfg.svh ====
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// mailbox word and apb address sizes
`define BRIDGE_WORD_W       32
`define BRIDGE_APB_ADDR_W   8

// one command carries this many parameter words
`define BRIDGE_PARAM_WORDS  4

// request channels, fixed by the command set
`define BRIDGE_N_CHAN       7

// register byte offsets, params occupy 0x08 to 0x14
`define BRIDGE_REG_STATUS   8'h00
`define BRIDGE_REG_COMMAND  8'h04
`define BRIDGE_REG_PARAM0   8'h08
`define BRIDGE_REG_RESULT   8'h18

`endif

// ==== source/bridge_pkg.sv ====
`include "bridge_cfg.svh"

package bridge_pkg;

    typedef logic [`BRIDGE_WORD_W-1:0] bridge_word_t;

    // channel index, lower value wins arbitration
    typedef enum logic [2:0] {
        chan_ready_to_run          = 3'd0,
        chan_debug_event_log       = 3'd1,
        chan_dataslot_read         = 3'd2,
        chan_dataslot_write        = 3'd3,
        chan_dataslot_flush        = 3'd4,
        chan_get_dataslot_filename = 3'd5,
        chan_open_dataslot_file    = 3'd6
    } req_chan_e;

    typedef enum logic [15:0] {
        cmd_ready_to_run          = 16'h0140,
        cmd_debug_event_log       = 16'h0141,
        cmd_dataslot_read         = 16'h0180,
        cmd_dataslot_write        = 16'h0184,
        cmd_dataslot_flush        = 16'h018A,
        cmd_get_dataslot_filename = 16'h0190,
        cmd_open_dataslot_file    = 16'h0192
    } bridge_cmd_e;

    typedef enum logic [1:0] {
        result_ok        = 2'd0,
        result_not_found = 2'd1,
        result_busy      = 2'd2,
        result_error     = 2'd3
    } bridge_result_e;

    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_posted   = 2'd1,
        st_complete = 2'd2
    } req_state_e;

    typedef struct packed {
        logic [15:0] event_code;
    } debug_event_log_param_t;

    // shared by read and write
    typedef struct packed {
        logic [15:0] slot_id;
        logic [31:0] slot_offset;
        logic [31:0] bridge_addr;
        logic [31:0] length;
    } dataslot_xfer_param_t;

    typedef struct packed {
        logic [15:0] slot_id;
    } dataslot_flush_param_t;

    typedef struct packed {
        logic [15:0] slot_id;
        logic [31:0] bridge_addr;
    } get_filename_param_t;

    typedef struct packed {
        logic [31:0] bridge_addr;
        logic [31:0] flags;
    } open_file_param_t;

    typedef struct packed {
        debug_event_log_param_t debug;
        dataslot_xfer_param_t   read;
        dataslot_xfer_param_t   write;
        dataslot_flush_param_t  flush;
        get_filename_param_t    filename;
        open_file_param_t       open;
    } core_params_t;

    typedef struct packed {
        bridge_word_t [`BRIDGE_PARAM_WORDS-1:0] word;
    } bridge_param_t;

    typedef struct packed {
        logic                          psel;
        logic                          penable;
        logic                          pwrite;
        logic [`BRIDGE_APB_ADDR_W-1:0] paddr;
        bridge_word_t                  pwdata;
    } apb_req_t;

    typedef struct packed {
        bridge_word_t prdata;
        logic         pready;
        logic         pslverr;
    } apb_rsp_t;

    // unnamed words stay zero, 16-bit fields land zero-extended
    function automatic bridge_param_t debug_event_log_param_expand(debug_event_log_param_t p);
        bridge_param_t w;
        w = '0;
        w.word[0][15:0] = p.event_code;
        return w;
    endfunction

    function automatic bridge_param_t dataslot_xfer_param_expand(dataslot_xfer_param_t p);
        bridge_param_t w;
        w = '0;
        w.word[0][15:0] = p.slot_id;
        w.word[1] = p.slot_offset;
        w.word[2] = p.bridge_addr;
        w.word[3] = p.length;
        return w;
    endfunction

    function automatic bridge_param_t dataslot_flush_param_expand(dataslot_flush_param_t p);
        bridge_param_t w;
        w = '0;
        w.word[0][15:0] = p.slot_id;
        return w;
    endfunction

    function automatic bridge_param_t get_filename_param_expand(get_filename_param_t p);
        bridge_param_t w;
        w = '0;
        w.word[0][15:0] = p.slot_id;
        w.word[1] = p.bridge_addr;
        return w;
    endfunction

    function automatic bridge_param_t open_file_param_expand(open_file_param_t p);
        bridge_param_t w;
        w = '0;
        w.word[0] = p.bridge_addr;
        w.word[1] = p.flags;
        return w;
    endfunction

endpackage

// ==== source/bridge_req_arbiter.sv ====
`include "bridge_cfg.svh"

module bridge_req_arbiter (
    input  logic [`BRIDGE_N_CHAN-1:0] core_valid,
    output logic                      grant_valid,
    output bridge_pkg::req_chan_e     grant_chan,
    output bridge_pkg::bridge_cmd_e   grant_cmd
);

    // scan from the top so the lowest valid index is the last write
    always_comb begin
        grant_chan = bridge_pkg::chan_ready_to_run;
        for (int i = `BRIDGE_N_CHAN - 1; i >= 0; i--) begin
            if (core_valid[i]) begin
                grant_chan = bridge_pkg::req_chan_e'(i);
            end
        end
    end

    assign grant_valid = |core_valid;

    always_comb begin
        case (grant_chan)
            bridge_pkg::chan_ready_to_run:
                grant_cmd = bridge_pkg::cmd_ready_to_run;
            bridge_pkg::chan_debug_event_log:
                grant_cmd = bridge_pkg::cmd_debug_event_log;
            bridge_pkg::chan_dataslot_read:
                grant_cmd = bridge_pkg::cmd_dataslot_read;
            bridge_pkg::chan_dataslot_write:
                grant_cmd = bridge_pkg::cmd_dataslot_write;
            bridge_pkg::chan_dataslot_flush:
                grant_cmd = bridge_pkg::cmd_dataslot_flush;
            bridge_pkg::chan_get_dataslot_filename:
                grant_cmd = bridge_pkg::cmd_get_dataslot_filename;
            bridge_pkg::chan_open_dataslot_file:
                grant_cmd = bridge_pkg::cmd_open_dataslot_file;
            default:
                grant_cmd = bridge_pkg::cmd_ready_to_run;
        endcase
    end

endmodule

// ==== source/bridge_param_pack.sv ====
module bridge_param_pack (
    input  logic                     req,
    input  logic                     reset,
    input  logic                     capture,
    input  bridge_pkg::req_chan_e    capture_chan,
    input  bridge_pkg::core_params_t core_params,
    output bridge_pkg::bridge_param_t params
);

    bridge_pkg::bridge_param_t expanded;

    // only the granted channel's field is looked at
    always_comb begin
        case (capture_chan)
            bridge_pkg::chan_debug_event_log: begin
                expanded = bridge_pkg::debug_event_log_param_expand(core_params.debug);
            end
            bridge_pkg::chan_dataslot_read: begin
                expanded = bridge_pkg::dataslot_xfer_param_expand(core_params.read);
            end
            bridge_pkg::chan_dataslot_write: begin
                expanded = bridge_pkg::dataslot_xfer_param_expand(core_params.write);
            end
            bridge_pkg::chan_dataslot_flush: begin
                expanded = bridge_pkg::dataslot_flush_param_expand(core_params.flush);
            end
            bridge_pkg::chan_get_dataslot_filename: begin
                expanded = bridge_pkg::get_filename_param_expand(core_params.filename);
            end
            bridge_pkg::chan_open_dataslot_file: begin
                expanded = bridge_pkg::open_file_param_expand(core_params.open);
            end
            // ready_to_run carries no parameters
            default: begin
                expanded = '0;
            end
        endcase
    end

    // words hold until the next capture so the host may read in any order
    always_ff @(posedge req) begin
        if (reset) begin
            params <= '0;
        end else if (capture) begin
            params <= expanded;
        end
    end

endmodule

// ==== source/bridge_req_ctrl.sv ====
`include "bridge_cfg.svh"

module bridge_req_ctrl (
    input  logic                        req,
    input  logic                        reset,
    input  logic [`BRIDGE_N_CHAN-1:0]   core_valid,
    input  bridge_pkg::core_params_t    core_params,
    input  logic                        doorbell,
    input  bridge_pkg::bridge_result_e  host_result,
    output bridge_pkg::bridge_cmd_e     load_cmd,
    output logic                        load,
    output bridge_pkg::bridge_param_t   params,
    output logic                        pending,
    output logic [`BRIDGE_N_CHAN-1:0]   core_done,
    output bridge_pkg::bridge_result_e  core_result
);

    logic                  grant_valid;
    bridge_pkg::req_chan_e grant_chan;
    bridge_pkg::bridge_cmd_e grant_cmd;
    logic                  capture;
    bridge_pkg::req_chan_e served_chan;
    bridge_pkg::req_state_e state;

    bridge_req_arbiter arbiter_i (
        .core_valid  (core_valid),
        .grant_valid (grant_valid),
        .grant_chan  (grant_chan),
        .grant_cmd   (grant_cmd)
    );

    // a grant is only taken while no request is outstanding
    assign capture = (state == bridge_pkg::st_idle) && grant_valid;

    bridge_param_pack param_pack_i (
        .req          (req),
        .reset        (reset),
        .capture      (capture),
        .capture_chan (grant_chan),
        .core_params  (core_params),
        .params       (params)
    );

    always_ff @(posedge req) begin
        if (reset) begin
            state <= bridge_pkg::st_idle;
        end else begin
            case (state)
                bridge_pkg::st_idle: begin
                    if (grant_valid) begin
                        state <= bridge_pkg::st_posted;
                    end
                end
                bridge_pkg::st_posted: begin
                    if (doorbell) begin
                        state <= bridge_pkg::st_complete;
                    end
                end
                default: begin
                    state <= bridge_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge req) begin
        if (capture) begin
            served_chan <= grant_chan;
        end
    end

    // mailbox latches the opcode on the same edge as the channel
    assign load     = capture;
    assign load_cmd = grant_cmd;
    assign pending  = (state == bridge_pkg::st_posted);

    always_comb begin
        core_done = '0;
        if (state == bridge_pkg::st_complete) begin
            core_done[served_chan] = 1'b1;
        end
    end

    // already latched by the doorbell edge, valid during the done cycle
    assign core_result = host_result;

endmodule

// ==== source/bridge_apb_mailbox.sv ====
`include "bridge_cfg.svh"

module bridge_apb_mailbox (
    input  logic                       req,
    input  logic                       reset,
    input  bridge_pkg::apb_req_t       apb,
    output bridge_pkg::apb_rsp_t       apb_rsp,
    input  logic                       load,
    input  bridge_pkg::bridge_cmd_e    load_cmd,
    input  bridge_pkg::bridge_param_t  params,
    input  logic                       pending,
    output logic                       doorbell,
    output bridge_pkg::bridge_result_e host_result,
    output logic                       host_irq
);

    bridge_pkg::bridge_cmd_e    command_q;
    bridge_pkg::bridge_result_e result_q;
    bridge_pkg::bridge_word_t   rdata;
    logic [`BRIDGE_APB_ADDR_W-1:0] param_off;
    logic [1:0]                 param_idx;
    logic                       access;
    logic                       mapped;
    logic                       read_only;
    logic                       slverr;

    assign access    = apb.psel && apb.penable;
    assign param_off = apb.paddr - `BRIDGE_REG_PARAM0;
    assign param_idx = param_off[3:2];

    // register map decode, only RESULT is writable
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b1;
        rdata     = '0;
        case (apb.paddr)
            `BRIDGE_REG_STATUS: begin
                rdata[0] = pending;
            end
            `BRIDGE_REG_COMMAND: begin
                rdata[15:0] = command_q;
            end
            `BRIDGE_REG_PARAM0,
            `BRIDGE_REG_PARAM0 + 8'h04,
            `BRIDGE_REG_PARAM0 + 8'h08,
            `BRIDGE_REG_PARAM0 + 8'h0C: begin
                rdata = params.word[param_idx];
            end
            `BRIDGE_REG_RESULT: begin
                rdata[1:0] = result_q;
                read_only  = 1'b0;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    // a RESULT write with nothing pending is rejected like a read-only write
    assign slverr   = access && (!mapped || (apb.pwrite && (read_only || !pending)));
    assign doorbell = access && apb.pwrite && mapped && !read_only && pending;

    always_ff @(posedge req) begin
        if (reset) begin
            command_q <= bridge_pkg::bridge_cmd_e'(16'h0000);
        end else if (load) begin
            command_q <= load_cmd;
        end
    end

    always_ff @(posedge req) begin
        if (reset) begin
            result_q <= bridge_pkg::result_ok;
        end else if (doorbell) begin
            result_q <= bridge_pkg::bridge_result_e'(apb.pwdata[1:0]);
        end
    end

    // no wait states
    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = slverr;

    assign host_result = result_q;
    assign host_irq    = pending;

endmodule

// ==== source/bridge_req_top.sv ====
`include "bridge_cfg.svh"

module bridge_req_top (
    input  logic                       req,
    input  logic                       reset,
    input  logic [`BRIDGE_N_CHAN-1:0]  core_valid,
    input  bridge_pkg::core_params_t   core_params,
    output logic [`BRIDGE_N_CHAN-1:0]  core_done,
    output bridge_pkg::bridge_result_e core_result,
    input  bridge_pkg::apb_req_t       apb,
    output bridge_pkg::apb_rsp_t       apb_rsp,
    output logic                       host_irq
);

    logic                       load;
    bridge_pkg::bridge_cmd_e    load_cmd;
    bridge_pkg::bridge_param_t  params;
    logic                       pending;
    logic                       doorbell;
    bridge_pkg::bridge_result_e host_result;

    // core side handshake and request sequencing
    bridge_req_ctrl ctrl_i (
        .req         (req),
        .reset       (reset),
        .core_valid  (core_valid),
        .core_params (core_params),
        .doorbell    (doorbell),
        .host_result (host_result),
        .load_cmd    (load_cmd),
        .load        (load),
        .params      (params),
        .pending     (pending),
        .core_done   (core_done),
        .core_result (core_result)
    );

    // host side register window
    bridge_apb_mailbox mailbox_i (
        .req         (req),
        .reset       (reset),
        .apb         (apb),
        .apb_rsp     (apb_rsp),
        .load        (load),
        .load_cmd    (load_cmd),
        .params      (params),
        .pending     (pending),
        .doorbell    (doorbell),
        .host_result (host_result),
        .host_irq    (host_irq)
    );

endmodule

// ==== test/bridge_req_checker.sv ====
`include "bridge_cfg.svh"

module bridge_req_checker (
    input logic                      req,
    input logic                      reset,
    input logic [`BRIDGE_N_CHAN-1:0] core_done,
    input logic                      host_irq,
    input bridge_pkg::apb_req_t      apb,
    input bridge_pkg::apb_rsp_t      apb_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    logic access;
    logic result_write;

    assign access       = apb.psel && apb.penable;
    assign result_write = access && apb.pwrite && (apb.paddr == `BRIDGE_REG_RESULT);

    done_single_cycle: assert property (@(posedge req) disable iff (reset)
        (|core_done) |=> (core_done == '0))
        else $error("core_done held for more than one cycle");

    // the interrupt only clears through the RESULT doorbell
    irq_drops_on_doorbell: assert property (@(posedge req) disable iff (reset)
        $fell(host_irq) |-> $past(result_write))
        else $error("host_irq dropped without a RESULT write");

    bad_write_errors: assert property (@(posedge req) disable iff (reset)
        (access && apb.pwrite && (apb.paddr != `BRIDGE_REG_RESULT || !host_irq))
            |-> apb_rsp.pslverr)
        else $error("rejected write returned no pslverr");

    // done only in the cycle after the RESULT write access
    done_after_doorbell: assert property (@(posedge req) disable iff (reset)
        (|core_done) |-> $past(result_write))
        else $error("core_done without a preceding RESULT write");

endmodule

// ==== test/bridge_req_tb.sv ====
`include "bridge_cfg.svh"

module bridge_req_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_chan      = `BRIDGE_N_CHAN;
    localparam int prio_rounds = 16;
    localparam int bp_requests = 40;
    localparam int max_delay   = 20;
    // at most 152 requests of about 16 cycles, host delays and margin on top
    localparam int timeout_cycles = 4000;

    typedef enum logic [1:0] {
        m_idle,
        m_posted,
        m_complete
    } model_state_e;

    logic                       req;
    logic                       reset;
    logic [n_chan-1:0]          core_valid;
    bridge_pkg::core_params_t   core_params;
    logic [n_chan-1:0]          core_done;
    bridge_pkg::bridge_result_e core_result;
    bridge_pkg::apb_req_t       apb;
    bridge_pkg::apb_rsp_t       apb_rsp;
    logic                       host_irq;

    logic [31:0]       seed;
    int                cycle_count = 0;
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                raised_count [n_chan];
    int                done_count [n_chan];
    model_state_e      m_state;
    int                exp_chan;
    logic [1:0]        exp_result;
    logic [n_chan-1:0] done_s;
    logic [n_chan-1:0] just_done;
    logic [31:0]       prdata_s;
    logic              pslverr_s;
    logic              pready_s;
    logic              irq_s;

    bridge_req_top bridge_req_top_i (
        .req         (req),
        .reset       (reset),
        .core_valid  (core_valid),
        .core_params (core_params),
        .core_done   (core_done),
        .core_result (core_result),
        .apb         (apb),
        .apb_rsp     (apb_rsp),
        .host_irq    (host_irq)
    );

    bind bridge_req_top bridge_req_checker checker_i (
        .req       (req),
        .reset     (reset),
        .core_done (core_done),
        .host_irq  (host_irq),
        .apb       (apb),
        .apb_rsp   (apb_rsp)
    );

    always #5 req = ~req;

    always @(posedge req) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int lowest_index(input logic [n_chan-1:0] mask);
        for (int i = 0; i < n_chan; i++) begin
            if (mask[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic logic [15:0] opcode_of(input int ch);
        case (ch)
            0: return 16'h0140;
            1: return 16'h0141;
            2: return 16'h0180;
            3: return 16'h0184;
            4: return 16'h018A;
            5: return 16'h0190;
            default: return 16'h0192;
        endcase
    endfunction

    // word layout per command, 16-bit fields zero-extended
    function automatic bridge_pkg::bridge_param_t expected_words(input int ch,
                                                                 input bridge_pkg::core_params_t p);
        bridge_pkg::bridge_param_t w;
        w = '0;
        case (ch)
            1: begin
                w.word[0] = 32'(p.debug.event_code);
            end
            2: begin
                w.word[0] = 32'(p.read.slot_id);
                w.word[1] = p.read.slot_offset;
                w.word[2] = p.read.bridge_addr;
                w.word[3] = p.read.length;
            end
            3: begin
                w.word[0] = 32'(p.write.slot_id);
                w.word[1] = p.write.slot_offset;
                w.word[2] = p.write.bridge_addr;
                w.word[3] = p.write.length;
            end
            4: begin
                w.word[0] = 32'(p.flush.slot_id);
            end
            5: begin
                w.word[0] = 32'(p.filename.slot_id);
                w.word[1] = p.filename.bridge_addr;
            end
            6: begin
                w.word[0] = p.open.bridge_addr;
                w.word[1] = p.open.flags;
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic randomize_params(input int ch);
        case (ch)
            1: core_params.debug.event_code = 16'(next_random());
            2: begin
                core_params.read.slot_id     = 16'(next_random());
                core_params.read.slot_offset = next_random();
                core_params.read.bridge_addr = next_random();
                core_params.read.length      = next_random();
            end
            3: begin
                core_params.write.slot_id     = 16'(next_random());
                core_params.write.slot_offset = next_random();
                core_params.write.bridge_addr = next_random();
                core_params.write.length      = next_random();
            end
            4: core_params.flush.slot_id = 16'(next_random());
            5: begin
                core_params.filename.slot_id     = 16'(next_random());
                core_params.filename.bridge_addr = next_random();
            end
            6: begin
                core_params.open.bridge_addr = next_random();
                core_params.open.flags       = next_random();
            end
            default: begin
            end
        endcase
    endtask

    // mid-cycle compare against the reference FSM
    task automatic check_cycle();
        logic [n_chan-1:0] exp_done;
        exp_done = '0;
        if (m_state == m_complete) begin
            exp_done[exp_chan] = 1'b1;
        end
        if (core_done !== exp_done) begin
            report_error($sformatf("core_done %b, expected %b", core_done, exp_done));
        end
        if (m_state == m_complete && core_result !== exp_result) begin
            report_error($sformatf("core_result %0d, expected %0d", core_result, exp_result));
        end
        if (host_irq !== (m_state == m_posted)) begin
            report_error($sformatf("host_irq %b while model pending is %b",
                                   host_irq, m_state == m_posted));
        end
        for (int ch = 0; ch < n_chan; ch++) begin
            if (core_done[ch] === 1'b1) begin
                done_count[ch]++;
            end
        end
    endtask

    task automatic advance_model();
        case (m_state)
            m_idle: begin
                if (core_valid != '0) begin
                    exp_chan = lowest_index(core_valid);
                    m_state  = m_posted;
                end
            end
            m_posted: begin
                if (apb.psel && apb.penable && apb.pwrite && apb.paddr == `BRIDGE_REG_RESULT) begin
                    exp_result = apb.pwdata[1:0];
                    m_state    = m_complete;
                end
            end
            default: begin
                m_state = m_idle;
            end
        endcase
    endtask

    // one clock: sample mid-cycle, step the model at the edge, drive 1 ns later
    task automatic tick();
        @(negedge req);
        check_cycle();
        done_s    = core_done;
        prdata_s  = apb_rsp.prdata;
        pslverr_s = apb_rsp.pslverr;
        pready_s  = apb_rsp.pready;
        irq_s     = host_irq;
        @(posedge req);
        advance_model();
        #1;
        core_valid = core_valid & ~done_s;
        just_done  = done_s;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        apb.pwdata  = '0;
        tick();
        apb.penable = 1'b1;
        tick();
        if (pready_s !== 1'b1) begin
            report_error($sformatf("pready low in the access phase of a read at %h", addr));
        end
        data = prdata_s;
        err  = pslverr_s;
        apb  = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        tick();
        apb.penable = 1'b1;
        tick();
        if (pready_s !== 1'b1) begin
            report_error($sformatf("pready low in the access phase of a write at %h", addr));
        end
        err = pslverr_s;
        apb = '0;
    endtask

    // a channel just dropped by done waits at least one driven cycle
    task automatic raise_requests(input logic [n_chan-1:0] mask, input int limit, inout int raised);
        for (int ch = 0; ch < n_chan; ch++) begin
            if (mask[ch] && !core_valid[ch] && !just_done[ch] && raised < limit) begin
                randomize_params(ch);
                core_valid[ch] = 1'b1;
                raised_count[ch]++;
                raised++;
            end
        end
    endtask

    task automatic serve_one(input int delay);
        logic [31:0]               data;
        logic                      err;
        logic [1:0]                code;
        bridge_pkg::bridge_param_t words;
        while (!irq_s) begin
            tick();
        end
        repeat (delay) tick();
        words = expected_words(exp_chan, core_params);
        apb_read(`BRIDGE_REG_COMMAND, data, err);
        if (err || data !== {16'h0, opcode_of(exp_chan)}) begin
            report_error($sformatf("COMMAND %h, expected %h for channel %0d",
                                   data, opcode_of(exp_chan), exp_chan));
        end
        for (int i = 0; i < `BRIDGE_PARAM_WORDS; i++) begin
            apb_read(`BRIDGE_REG_PARAM0 + 8'(4 * i), data, err);
            if (err || data !== words.word[i]) begin
                report_error($sformatf("PARAM%0d %h, expected %h", i, data, words.word[i]));
            end
        end
        code = 2'(next_random() >> 16);
        apb_write(`BRIDGE_REG_RESULT, {30'h0, code}, err);
        if (err) begin
            report_error("RESULT write while pending returned pslverr");
        end
        apb_read(`BRIDGE_REG_STATUS, data, err);
        if (err || data !== 32'h0) begin
            report_error($sformatf("STATUS %h after completion, expected 0", data));
        end
    endtask

    initial begin
        int                errors_before;
        int                n;
        int                done_before;
        int                done_after;
        logic [n_chan-1:0] mask;
        logic [31:0]       data;
        logic [31:0]       old_cmd;
        logic [31:0]       old_res;
        logic              err;
        req         = 1'b0;
        reset       = 1'b1;
        core_valid  = '0;
        core_params = '0;
        apb         = '0;
        seed        = 32'h9dafd623;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int ch = 0; ch < n_chan; ch++) begin
            raised_count[ch] = 0;
            done_count[ch]   = 0;
        end
        m_state    = m_idle;
        exp_chan   = 0;
        exp_result = 2'd0;
        done_s     = '0;
        just_done  = '0;
        prdata_s   = '0;
        pslverr_s  = 1'b0;
        pready_s   = 1'b0;
        irq_s      = 1'b0;
        repeat (16) @(posedge req);
        #1;
        reset = 1'b0;

        errors_before = errors;
        if (core_done !== '0 || host_irq !== 1'b0) begin
            report_error("core_done or host_irq not low after reset");
        end
        for (int a = 0; a <= 8'h18; a += 4) begin
            apb_read(8'(a), data, err);
            if (err || data !== 32'h0) begin
                report_error($sformatf("register %h reads %h after reset", a, data));
            end
        end
        finish_test("reset_state", errors_before);

        // whole masks at once, served lowest index first
        errors_before = errors;
        for (int r = 0; r < prio_rounds; r++) begin
            mask = n_chan'(next_random() >> 16);
            mask[(next_random() >> 16) % n_chan] = 1'b1;
            n = 0;
            raise_requests(mask, n_chan, n);
            while (core_valid != '0) begin
                serve_one(0);
            end
        end
        finish_test("priority_packing_routing", errors_before);

        errors_before = errors;
        done_before = 0;
        for (int ch = 0; ch < n_chan; ch++) begin
            done_before += done_count[ch];
        end
        apb_read(`BRIDGE_REG_COMMAND, old_cmd, err);
        apb_read(`BRIDGE_REG_RESULT, old_res, err);
        apb_write(8'h40, 32'h1, err);
        if (!err) begin
            report_error("write to unmapped address 0x40 gave no pslverr");
        end
        apb_read(8'h1C, data, err);
        if (!err) begin
            report_error("read of unmapped address 0x1C gave no pslverr");
        end
        apb_write(`BRIDGE_REG_COMMAND, 32'hFFFF, err);
        if (!err) begin
            report_error("write to COMMAND gave no pslverr");
        end
        // a code that differs from the stored one, so a stray store shows up
        apb_write(`BRIDGE_REG_RESULT, {30'h0, ~old_res[1:0]}, err);
        if (!err) begin
            report_error("RESULT write while idle gave no pslverr");
        end
        apb_read(`BRIDGE_REG_COMMAND, data, err);
        if (data !== old_cmd) begin
            report_error($sformatf("COMMAND changed to %h from %h", data, old_cmd));
        end
        apb_read(`BRIDGE_REG_RESULT, data, err);
        if (data !== old_res) begin
            report_error($sformatf("RESULT changed to %h from %h", data, old_res));
        end
        apb_read(`BRIDGE_REG_STATUS, data, err);
        if (err || data !== 32'h0) begin
            report_error($sformatf("STATUS %h after rejected accesses", data));
        end
        done_after = 0;
        for (int ch = 0; ch < n_chan; ch++) begin
            done_after += done_count[ch];
        end
        if (done_after != done_before) begin
            report_error("rejected APB accesses produced a done pulse");
        end
        finish_test("apb_errors", errors_before);

        // new requests pile up while the host is slow
        errors_before = errors;
        n = 0;
        while (n < bp_requests || core_valid != '0) begin
            if (n < bp_requests) begin
                mask = n_chan'(next_random() >> 20);
                raise_requests(mask, bp_requests, n);
            end
            if (core_valid != '0) begin
                serve_one(int'((next_random() >> 16) % (max_delay + 1)));
            end else begin
                tick();
            end
        end
        for (int ch = 0; ch < n_chan; ch++) begin
            if (done_count[ch] != raised_count[ch]) begin
                report_error($sformatf("channel %0d raised %0d requests but got %0d done",
                                       ch, raised_count[ch], done_count[ch]));
            end
        end
        finish_test("back_pressure", errors_before);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/bridge_pkg.sv
source/bridge_req_arbiter.sv
source/bridge_param_pack.sv
source/bridge_req_ctrl.sv
source/bridge_apb_mailbox.sv
source/bridge_req_top.sv
test/bridge_req_checker.sv
test/bridge_req_tb.sv

// ==== Bender.yml ====
package:
  name: bridge_req

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/bridge_pkg.sv
      - source/bridge_req_arbiter.sv
      - source/bridge_param_pack.sv
      - source/bridge_req_ctrl.sv
      - source/bridge_apb_mailbox.sv
      - source/bridge_req_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/bridge_req_checker.sv
      - test/bridge_req_tb.sv
